// ==== datapath16.f ====
logic/datapath16_pkg.sv
logic/rf_if.sv
logic/reg_file.sv
logic/instr_decode.sv
logic/alu_exec.sv
logic/datapath16_top.sv
sim/tb_clock_gen.sv
sim/datapath16_sva.sv
sim/datapath16_tb.sv

// ==== logic/alu_exec.sv ====
// stage 2: runs the alu on the register file operands, drives the write-back
// and registers the result outputs. write and result land on the same edge.
`timescale 1ns/1ps

module alu_exec
    import datapath16_pkg::*;
(
    input  logic       CLK,
    input  logic       rst_n,
    input  ex_ctrl_t   ex_ctrl,
    rf_if.exec_mp      rf,
    output word_t      result,
    output logic       result_valid,
    output logic       result_zero,
    output reg_addr_t  result_rd
);

    word_t              op_a;     // ra operand from the register file.
    word_t              op_b;     // rb operand from the register file.
    logic [SHAMT_W-1:0] shamt;    // shift distance.
    word_t              alu_out;

    assign op_a  = rf.rd_data_a;
    assign op_b  = rf.rd_data_b;
    assign shamt = op_b[SHAMT_W-1:0];  // only the low bits of rb count.

    always_comb
    begin
        unique case (ex_ctrl.op)
            OP_ADD:  alu_out = op_a + op_b;
            OP_SUB:  alu_out = op_a - op_b;
            OP_AND:  alu_out = op_a & op_b;
            OP_OR:   alu_out = op_a | op_b;
            OP_XOR:  alu_out = op_a ^ op_b;
            OP_SHL:  alu_out = op_a << shamt;
            OP_SHR:  alu_out = op_a >> shamt;  // logical, zero fill.
            OP_LDI:  alu_out = ex_ctrl.imm;
            default: alu_out = '0;             // nop never reaches here valid.
        endcase
    end

    // write-back straight from the current stage 2 contents.
    assign rf.wr_en   = ex_ctrl.valid && (ex_ctrl.rd != '0);  // r0 target is not written.
    assign rf.wr_addr = ex_ctrl.rd;
    assign rf.wr_data = alu_out;

    // result strobe, still raised for rd == 0.
    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= ex_ctrl.valid;
        end
    end

    // result payload, held between valid results.
    always_ff @(posedge CLK)
    begin
        if (ex_ctrl.valid)
        begin
            result      <= alu_out;
            result_zero <= (alu_out == '0);
            result_rd   <= ex_ctrl.rd;
        end
    end

endmodule

// ==== logic/datapath16_pkg.sv ====
// shared types and encodings for the 16-bit register-and-alu datapath.
// import into any module that touches words, register numbers or opcodes.
package datapath16_pkg;

    typedef logic [15:0] word_t;      // data word, register contents and alu result.
    typedef logic [2:0]  reg_addr_t;  // register number, r0 to r7.
    typedef logic [15:0] instr_t;     // raw instruction word.

    localparam int NUM_REGS = 8;      // register file depth.
    localparam int SHAMT_W  = 4;      // shift amount taken from the rb operand.

    // instruction field positions.
    localparam int OPC_HI = 15;
    localparam int OPC_LO = 12;
    localparam int RD_HI  = 11;
    localparam int RD_LO  = 9;
    localparam int RA_HI  = 8;
    localparam int RA_LO  = 6;
    localparam int RB_HI  = 5;
    localparam int RB_LO  = 3;
    localparam int IMM_HI = 7;
    localparam int IMM_LO = 0;

    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_AND = 4'd3,
        OP_OR  = 4'd4,
        OP_XOR = 4'd5,
        OP_SHL = 4'd6,
        OP_SHR = 4'd7,
        OP_LDI = 4'd8   // codes 9 to 15 are undefined and act as nop.
    } opcode_e;

    // stage 1 to stage 2 record.
    typedef struct packed {
        logic      valid;  // instruction produces a result.
        opcode_e   op;
        reg_addr_t rd;
        word_t     imm;    // imm8 zero-extended, ldi only.
    } ex_ctrl_t;

    // true for opcodes that produce a result and a write.
    function automatic logic op_is_exec(logic [3:0] code);
        return (code >= 4'(OP_ADD)) && (code <= 4'(OP_LDI));
    endfunction

endpackage

// ==== logic/datapath16_top.sv ====
// top level of the 16-bit register-and-alu datapath.
// one instruction per cycle on instr/instr_valid, results two edges later.
`timescale 1ns/1ps

module datapath16_top
    import datapath16_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  instr_t    instr,
    output word_t     result,
    output logic      result_valid,
    output logic      result_zero,
    output reg_addr_t result_rd
);

    rf_if     rf_bus ();  // read and write ports of the register file.
    ex_ctrl_t ex_ctrl;    // stage 1 to stage 2 record.

    // stage 1, decode and register read addresses.
    instr_decode u_decode (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rf          (rf_bus.decode_mp),
        .ex_ctrl     (ex_ctrl)
    );

    // register file, synchronous reads with bypass.
    reg_file u_reg_file (
        .CLK   (CLK),
        .rst_n (rst_n),
        .rf    (rf_bus.rf_mp)
    );

    // stage 2, alu and write-back.
    alu_exec u_exec (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .ex_ctrl      (ex_ctrl),
        .rf           (rf_bus.exec_mp),
        .result       (result),
        .result_valid (result_valid),
        .result_zero  (result_zero),
        .result_rd    (result_rd)
    );

endmodule

// ==== logic/instr_decode.sv ====
// stage 1: splits the incoming instruction, presents the read addresses to
// the register file and registers the control record for stage 2.
`timescale 1ns/1ps

module instr_decode
    import datapath16_pkg::*;
(
    input  logic          CLK,
    input  logic          rst_n,
    input  logic          instr_valid,
    input  instr_t        instr,
    rf_if.decode_mp       rf,
    output ex_ctrl_t      ex_ctrl
);

    logic [3:0] opc_raw;   // opcode bits, may hold undefined codes.
    reg_addr_t  rd_fld;    // destination register.
    reg_addr_t  ra_fld;    // first source register.
    reg_addr_t  rb_fld;    // second source register.
    logic [7:0] imm8_fld;  // ldi immediate, overlaps ra and rb.
    logic       exec_ok;   // strobed and a defined, non-nop opcode.
    opcode_e    op_next;
    word_t      imm_next;

    // field split.
    assign opc_raw  = instr[OPC_HI:OPC_LO];
    assign rd_fld   = instr[RD_HI:RD_LO];
    assign ra_fld   = instr[RA_HI:RA_LO];
    assign rb_fld   = instr[RB_HI:RB_LO];
    assign imm8_fld = instr[IMM_HI:IMM_LO];

    // read addresses go out straight from the instruction,
    // the register file samples them at the capture edge.
    assign rf.rd_addr_a = ra_fld;
    assign rf.rd_addr_b = rb_fld;

    assign exec_ok = instr_valid && op_is_exec(opc_raw);

    always_comb
    begin
        op_next  = exec_ok ? opcode_e'(opc_raw) : OP_NOP;  // undefined folds to nop.
        imm_next = '0;
        if (op_next == OP_LDI)
        begin
            imm_next = {8'h00, imm8_fld};  // zero extension.
        end
    end

    // valid bit is control state and takes the reset.
    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            ex_ctrl.valid <= 1'b0;
        end
        else
        begin
            ex_ctrl.valid <= exec_ok;
        end
    end

    // payload fields, meaningful only while valid is set.
    always_ff @(posedge CLK)
    begin
        ex_ctrl.op  <= op_next;
        ex_ctrl.rd  <= rd_fld;
        ex_ctrl.imm <= imm_next;
    end

endmodule

// ==== logic/reg_file.sv ====
// eight by 16 register file, two synchronous read ports and one write port.
// a read of the register written at the same edge returns the new value,
// r0 is hardwired to zero.
`timescale 1ns/1ps

module reg_file
    import datapath16_pkg::*;
(
    input logic CLK,
    input logic rst_n,
    rf_if.rf_mp rf
);

    word_t regs [NUM_REGS];  // storage; r0 slot is never written.
    word_t rd_next_a;        // bypassed read value for port a.
    word_t rd_next_b;        // bypassed read value for port b.
    logic  wr_live;          // write that will land at this edge.

    assign wr_live = rf.wr_en && (rf.wr_addr != '0);  // r0 writes dropped.

    // read mux with write-through bypass.
    function automatic word_t read_sel(
        input reg_addr_t addr,
        input logic      wr_hit,
        input reg_addr_t wr_addr,
        input word_t     wr_data,
        input word_t     stored
    );
        word_t value;
        if (addr == '0)
        begin
            value = '0;                     // r0 always reads zero.
        end
        else if (wr_hit && (addr == wr_addr))
        begin
            value = wr_data;                // forward the value being written.
        end
        else
        begin
            value = stored;
        end
        return value;
    endfunction

    always_comb
    begin
        rd_next_a = read_sel(rf.rd_addr_a, wr_live, rf.wr_addr, rf.wr_data,
                             regs[rf.rd_addr_a]);
        rd_next_b = read_sel(rf.rd_addr_b, wr_live, rf.wr_addr, rf.wr_data,
                             regs[rf.rd_addr_b]);
    end

    // storage, cleared on reset.
    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_live)
        begin
            regs[rf.wr_addr] <= rf.wr_data;
        end
    end

    // read data registers, one cycle after the address.
    always_ff @(posedge CLK)
    begin
        rf.rd_data_a <= rd_next_a;
        rf.rd_data_b <= rd_next_b;
    end

endmodule

// ==== logic/rf_if.sv ====
// bundle of the register file's two read ports and one write port.
// decode drives the read addresses, exec drives the write and takes the data.
`timescale 1ns/1ps

interface rf_if
    import datapath16_pkg::*;
;
    reg_addr_t rd_addr_a;  // operand a register.
    reg_addr_t rd_addr_b;  // operand b register.
    word_t     rd_data_a;  // registered read data a.
    word_t     rd_data_b;  // registered read data b.
    logic      wr_en;      // write strobe, already qualified with rd != 0.
    reg_addr_t wr_addr;
    word_t     wr_data;

    modport decode_mp (
        output rd_addr_a, rd_addr_b
    );

    // exec also consumes the read data as its operands.
    modport exec_mp (
        input  rd_data_a, rd_data_b,
        output wr_en, wr_addr, wr_data
    );

    modport rf_mp (
        input  rd_addr_a, rd_addr_b, wr_en, wr_addr, wr_data,
        output rd_data_a, rd_data_b
    );

endinterface

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the datapath testbench with Verilator, run it, and look for the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module datapath16_tb \
    -f datapath16.f \
    -o datapath16_sim

# The error limit lets the run reach the summary after an assertion failure.
output="$(./obj_dir/datapath16_sim +verilator+error+limit+1000 2>&1)" || true
echo "$output"

if grep -qF "All checks passed" <<< "$output"
then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== sim/datapath16_sva.sv ====
// protocol assertions on the datapath top level.
// attached to every datapath16_top by the bind at the end of this file.
`timescale 1ns/1ps

module datapath16_sva
    import datapath16_pkg::*;
(
    input logic   CLK,
    input logic   rst_n,
    input logic   instr_valid,
    input instr_t instr,
    input word_t  result,
    input logic   result_valid,
    input logic   result_zero
);

    int unsigned fail_count = 0;  // failed assertions so far.
    logic        no_exec;         // opcode is nop or undefined.

    assign no_exec = (instr[OPC_HI:OPC_LO] == 4'd0) || (instr[OPC_HI:OPC_LO] > 4'd8);

    // a reset edge always leaves the result strobe low.
    reset_quiet: assert property (@(posedge CLK) !rst_n |=> !result_valid)
    else
    begin
        $error("result_valid high after a reset edge");
        fail_count++;
    end

    zero_flag: assert property (@(posedge CLK) disable iff (!rst_n)
        (result_valid && result_zero) |-> (result == '0))
    else
    begin
        $error("result_zero set on a nonzero result");
        fail_count++;
    end

    // nop strobe followed by an idle cycle gives no result.
    nop_silent: assert property (@(posedge CLK) disable iff (!rst_n)
        ($past(instr_valid && no_exec, 2) && !$past(instr_valid)) |-> !result_valid)
    else
    begin
        $error("result_valid raised by a nop or undefined opcode");
        fail_count++;
    end

endmodule

bind datapath16_top datapath16_sva u_sva (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result       (result),
    .result_valid (result_valid),
    .result_zero  (result_zero)
);

// ==== sim/datapath16_tb.sv ====
// testbench for the 16-bit datapath. directed reset, bypass and r0 checks,
// then lfsr-driven instructions compared against a register-level model.
`timescale 1ns/1ps

module datapath16_tb
    import datapath16_pkg::*;
;
    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_MAX    = 32;    // upper bound on directed steps.
    localparam int RANDOM_CYCLES   = 2000;
    localparam int DRAIN_CYCLES    = 4;     // lets the last results come out.
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_MAX + RANDOM_CYCLES
                                     + DRAIN_CYCLES + 100;

    logic      CLK;
    logic      rst_n;
    logic      instr_valid;
    instr_t    instr;
    word_t     result;
    logic      result_valid;
    logic      result_zero;
    reg_addr_t result_rd;

    logic [15:0] lfsr_state = 16'd61;  // seed.
    word_t       model_regs [8];       // reference register file.
    instr_t      due_instr [$];        // instructions in flight, oldest first.
    logic        due_valid [$];
    int          word_errs = 0;
    int          addr_errs = 0;
    int          bit_errs = 0;
    int          other_errs = 0;
    int          results_seen = 0;

    tb_clock_gen #(.PERIOD_NS(10)) u_clk (.clk(CLK));

    datapath16_top UUT (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result       (result),
        .result_valid (result_valid),
        .result_zero  (result_zero),
        .result_rd    (result_rd)
    );

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // x^16+x^14+x^13+x^11+1.
    endfunction

    // one lfsr step per bit, newest bit lands in the lsb.
    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v          = {v[14:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    function automatic instr_t enc_rrr(input logic [3:0] op, input reg_addr_t rd,
                                       input reg_addr_t ra, input reg_addr_t rb);
        return {op, rd, ra, rb, 3'b000};
    endfunction

    function automatic instr_t enc_ldi(input reg_addr_t rd, input logic [7:0] imm);
        return {4'd8, rd, 1'b0, imm};
    endfunction

    function automatic logic is_exec_code(input logic [3:0] code);
        return (code != 4'd0) && (code <= 4'd8);  // 9 to 15 act as nop.
    endfunction

    // expected alu output on the model's current register contents.
    function automatic word_t model_result(input instr_t ins);
        word_t a;
        word_t b;
        a = model_regs[ins[8:6]];
        b = model_regs[ins[5:3]];
        case (ins[15:12])
            4'd1:    return a + b;
            4'd2:    return a - b;
            4'd3:    return a & b;
            4'd4:    return a | b;
            4'd5:    return a ^ b;
            4'd6:    return a << b[3:0];  // shift by low nibble of rb.
            4'd7:    return a >> b[3:0];
            4'd8:    return {8'h00, ins[7:0]};
            default: return '0;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            word_errs++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp)
        begin
            addr_errs++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            bit_errs++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    // compares the outputs for the instruction driven two steps back,
    // then retires its write into the model.
    task automatic check_due();
        instr_t ins;
        logic   v;
        word_t  exp;
        if (due_instr.size() < 2)
        begin
            return;
        end
        ins = due_instr.pop_front();
        v   = due_valid.pop_front();
        if (v && is_exec_code(ins[15:12]))
        begin
            exp = model_result(ins);
            check_bit("result_valid", result_valid, 1'b1);
            check_word("result", result, exp);
            check_bit("result_zero", result_zero, exp == '0);
            check_addr("result_rd", result_rd, ins[11:9]);
            if (ins[11:9] != 3'd0)
            begin
                model_regs[ins[11:9]] = exp;  // r0 stays zero.
            end
            if (result_valid === 1'b1)
            begin
                results_seen++;
            end
        end
        else
        begin
            check_bit("result_valid", result_valid, 1'b0);
        end
    endtask

    // one clock: check the settled outputs, then drive the next input.
    task automatic step_cycle(input logic v, input instr_t ins);
        @(posedge CLK);
        #1;
        check_due();
        instr_valid = v;
        instr       = ins;
        due_instr.push_back(ins);
        due_valid.push_back(v);
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timeout: stimulus did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        logic [15:0] bits;
        logic        v;
        instr_t      ins;
        int          total;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int r = 0; r < 8; r++)
        begin
            model_regs[r] = '0;
        end

        repeat (RESET_CYCLES) step_cycle(1'b0, '0);
        rst_n = 1'b1;

        // every register reads zero after reset, seen through or with r0.
        for (int r = 0; r < 8; r++)
        begin
            step_cycle(1'b1, enc_rrr(4'd4, 3'd0, reg_addr_t'(r), 3'd0));
        end

        // dependent chain, each step uses the value written just before.
        step_cycle(1'b1, enc_ldi(3'd1, 8'h5A));
        step_cycle(1'b1, enc_rrr(4'd1, 3'd2, 3'd1, 3'd1));
        step_cycle(1'b1, enc_rrr(4'd2, 3'd3, 3'd2, 3'd1));
        step_cycle(1'b1, enc_rrr(4'd5, 3'd4, 3'd3, 3'd2));
        step_cycle(1'b1, enc_rrr(4'd6, 3'd5, 3'd4, 3'd1));
        step_cycle(1'b1, enc_rrr(4'd7, 3'd6, 3'd5, 3'd1));
        step_cycle(1'b1, enc_rrr(4'd3, 3'd7, 3'd6, 3'd5));

        // r0 as target and as operand.
        step_cycle(1'b1, enc_ldi(3'd0, 8'hFF));
        step_cycle(1'b1, enc_rrr(4'd1, 3'd1, 3'd0, 3'd0));
        step_cycle(1'b1, enc_rrr(4'd4, 3'd2, 3'd0, 3'd1));

        // nop, undefined code and an unstrobed ldi leave r1 alone.
        step_cycle(1'b1, enc_rrr(4'd0, 3'd1, 3'd3, 3'd4));
        step_cycle(1'b1, enc_rrr(4'd11, 3'd1, 3'd3, 3'd4));
        step_cycle(1'b0, enc_ldi(3'd1, 8'h77));
        step_cycle(1'b0, '0);
        step_cycle(1'b1, enc_rrr(4'd4, 3'd0, 3'd1, 3'd0));

        for (int n = 0; n < RANDOM_CYCLES; n++)
        begin
            take_bits(1, bits);
            v = bits[0];
            take_bits(16, bits);
            ins = bits;
            if (ins[15:12] > 4'd8)
            begin
                take_bits(1, bits);
                if (bits[0])
                begin
                    ins[15:12] = ins[15:12] - 4'd8;  // fold most undefined codes to alu ops.
                end
            end
            step_cycle(v, ins);
        end

        repeat (DRAIN_CYCLES) step_cycle(1'b0, '0);

        if (results_seen < 100)
        begin
            other_errs++;
            $display("too few results were produced: %0d", results_seen);
        end

        total = word_errs + addr_errs + bit_errs + other_errs + int'(UUT.u_sva.fail_count);
        $display("errors: word %0d, addr %0d, bit %0d, other %0d, assertion %0d",
                 word_errs, addr_errs, bit_errs, other_errs, UUT.u_sva.fail_count);
        if (total == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sim/tb_clock_gen.sv ====
// free-running clock for the datapath testbench.
// instantiate once and connect clk to the dut clock.
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 10  // full clock period.
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;                   // start low so the first edge is a rising one.
    end

    always #(PERIOD_NS / 2) clk = ~clk;  // half period per toggle.

endmodule
